// ==== testbench/sound_stimulus.txt ====
# op a b c in hex: W port data, R port - expect, P port mask expect (poll), F fm_l fm_r
# S exp_l exp_r (after the pipeline), V vol_id level (0 master_l..5 line_r), I irq_{10,7,5}
V 0 1F 0
I 0 0 0
W 6 01 0
W 6 00 0
P E 80 80
R A 00 AA
R E 00 00
W C E1 0
R A 00 04
R A 00 05
R E 00 00
F 1000 F000 0
W 4 04 0
W 5 DD 0
W C D1 0
W C 10 0
W C C0 0
S 1000 0000 0
W C D3 0
S 0800 F800 0
W 4 36 0
W 5 A8 0
V 2 15 0
R 5 00 A8
W 4 80 0
W 5 AD 0
W 4 28 0
W 5 B7 0
V 2 17 0
V 3 0E 0
R 5 00 A6
W 4 00 0
W 5 00 0
V 2 1F 0
V 3 1F 0
V 0 1F 0
W 4 80 0
W 5 04 0
W C F2 0
I 2 0 0
W 4 82 0
R 5 00 01
R E 00 00
I 0 0 0
R 5 00 00

// ==== sim.f ====
rtl/sound_pkg.sv
rtl/audio_pkg.sv
rtl/io_bus_if.sv
rtl/tick_gen.sv
rtl/sound_dsp.sv
rtl/sound_mixer_regs.sv
rtl/sample_mixer.sv
rtl/sound_card.sv
testbench/tb_clock_gen.sv
testbench/sound_card_checker.sv
testbench/sound_card_tb.sv

// ==== Bender.yml ====
package:
  name: sound_card

sources:
  - rtl/sound_pkg.sv
  - rtl/audio_pkg.sv
  - rtl/io_bus_if.sv
  - rtl/tick_gen.sv
  - rtl/sound_dsp.sv
  - rtl/sound_mixer_regs.sv
  - rtl/sample_mixer.sv
  - rtl/sound_card.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sound_card_checker.sv
      - testbench/sound_card_tb.sv

// ==== testbench/sound_card_tb.sv ====
`timescale 1ns/100ps

module sound_card_tb;

	import sound_pkg::*;
	import audio_pkg::*;

	localparam int    POLL_LIMIT  = 200;
	localparam int    RESET_LIMIT = 50;
	localparam string STIM_FILE   = "testbench/sound_stimulus.txt";

	logic        clk;
	logic        rst_n;
	logic        cs;
	logic [3:0]  address;
	logic        read;
	logic        write;
	logic [7:0]  writedata;
	logic [7:0]  readdata;
	logic [27:0] clock_rate;
	logic [15:0] fm_sample_l;
	logic [15:0] fm_sample_r;
	logic        irq_5;
	logic        irq_7;
	logic        irq_10;
	logic [15:0] sample_l;
	logic [15:0] sample_r;
	vol_level_t  vol_master_l;
	vol_level_t  vol_master_r;
	vol_level_t  vol_cd_l;
	vol_level_t  vol_cd_r;
	vol_level_t  vol_line_l;
	vol_level_t  vol_line_r;
	logic [1:0]  vol_spk;

	tb_clock_gen clock_gen0 (.clk(clk), .rst_n(rst_n));

	sound_card #(.TICK_HZ(1000000), .RESET_US(3)) dut0 (.*);

	bind sound_card sound_card_checker checker0 (
		.clk(clk), .rst_n(rst_n), .cs(cs), .read(read), .readdata(readdata),
		.irq_5(irq_5), .irq_7(irq_7), .irq_10(irq_10),
		.vol_master_l(vol_master_l), .vol_master_r(vol_master_r),
		.vol_cd_l(vol_cd_l), .vol_cd_r(vol_cd_r),
		.vol_line_l(vol_line_l), .vol_line_r(vol_line_r), .vol_spk(vol_spk)
	);

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_sample(input string what, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_vol(input string what, input vol_level_t got, input vol_level_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_irq(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: irq {10,7,5} expected %b, got %b", $time, exp, got);
			stop_run();
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
		@(negedge clk);
		cs        = 1'b1;
		address   = addr;
		writedata = data;
		write     = 1'b1;
		@(negedge clk);
		write = 1'b0;
		cs    = 1'b0;
	endtask

	// readdata is registered, so it is valid one edge after the pulse
	task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
		@(negedge clk);
		cs      = 1'b1;
		address = addr;
		read    = 1'b1;
		@(negedge clk);
		read = 1'b0;
		cs   = 1'b0;
		data = readdata;
	endtask

	task automatic poll_port(input logic [3:0] addr, input logic [7:0] mask,
	                         input logic [7:0] exp);
		logic [7:0] d;
		int         tries;
		tries = 0;
		bus_read(addr, d);
		while ((d & mask) != exp) begin
			tries++;
			if (tries >= POLL_LIMIT) begin
				$display("timeout while polling port %h for %h at %0t ns", addr, exp, $time);
				stop_run();
			end
			bus_read(addr, d);
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			cycles++;
			if (cycles > RESET_LIMIT) begin
				$display("timeout waiting for reset to be released");
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic run_op(input byte op, input logic [31:0] a, input logic [31:0] b,
	                      input logic [31:0] c);
		logic [7:0] d;
		case (op)
			"W": bus_write(a[3:0], b[7:0]);
			"R": begin
				bus_read(a[3:0], d);
				check_byte($sformatf("readdata of port %h", a[3:0]), d, c[7:0]);
			end
			"P": poll_port(a[3:0], b[7:0], c[7:0]);
			"F": begin
				@(negedge clk);
				fm_sample_l = a[15:0];
				fm_sample_r = b[15:0];
			end
			"S": begin
				repeat (2) @(negedge clk); // two pipeline stages
				check_sample("sample_l", sample_l, a[15:0]);
				check_sample("sample_r", sample_r, b[15:0]);
			end
			"V": begin
				case (a[2:0])
					3'd0:    check_vol("vol_master_l", vol_master_l, b[4:0]);
					3'd1:    check_vol("vol_master_r", vol_master_r, b[4:0]);
					3'd2:    check_vol("vol_cd_l", vol_cd_l, b[4:0]);
					3'd3:    check_vol("vol_cd_r", vol_cd_r, b[4:0]);
					3'd4:    check_vol("vol_line_l", vol_line_l, b[4:0]);
					default: check_vol("vol_line_r", vol_line_r, b[4:0]);
				endcase
			end
			"I": check_irq({irq_10, irq_7, irq_5}, a[2:0]);
			default: begin
				$display("unknown operation '%c' in the stimulus file", op);
				stop_run();
			end
		endcase
	endtask

	// stop as soon as a bound assertion fires
	always @(posedge clk) begin
		if (dut0.checker0.fails != 0) begin
			$display("an assertion in the checker failed at %0t ns", $time);
			stop_run();
		end
	end

	initial begin
		int          fd;
		int          n;
		int          line_no;
		string       line;
		byte         op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;

		void'($urandom(88));
		cs          = 1'b0;
		address     = 4'h0;
		read        = 1'b0;
		write       = 1'b0;
		writedata   = 8'h00;
		clock_rate  = 28'd10_000_000;
		fm_sample_l = 16'h0000;
		fm_sample_r = 16'h0000;

		wait_reset_release();
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", STIM_FILE);
			stop_run();
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			line_no++;
			if (line.len() < 2 || line[0] == "#")
				continue; // blank or comment
			n = $sscanf(line, "%c %h %h %h", op, a, b, c);
			if (n != 4) begin
				$display("malformed stimulus line %0d", line_no);
				stop_run();
			end
			if (op != "S")
				repeat ($urandom_range(3, 0)) @(negedge clk); // idle gap, none before a sample
			run_op(op, a, b, c);
		end
		$fclose(fd);

		if (dut0.checker0.fails == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("the checker reported assertion failures");
			stop_run();
		end
	end

endmodule

// ==== testbench/sound_card_checker.sv ====
`timescale 1ns/100ps

module sound_card_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  cs,
	input logic                  read,
	input logic [7:0]            readdata,
	input logic                  irq_5,
	input logic                  irq_7,
	input logic                  irq_10,
	input sound_pkg::vol_level_t vol_master_l,
	input sound_pkg::vol_level_t vol_master_r,
	input sound_pkg::vol_level_t vol_cd_l,
	input sound_pkg::vol_level_t vol_cd_r,
	input sound_pkg::vol_level_t vol_line_l,
	input sound_pkg::vol_level_t vol_line_r,
	input logic [1:0]            vol_spk
);

	import sound_pkg::*;

	int unsigned fails = 0; // polled by the testbench

	// irq_sel is one-hot, so at most one line
	irq_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({irq_10, irq_7, irq_5}))
	else begin
		$error("more than one IRQ line is high");
		fails = fails + 1;
	end

	// readdata only moves after a read pulse
	readdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(read && cs) |-> $stable(readdata))
	else begin
		$error("readdata changed without a read");
		fails = fails + 1;
	end

	// every volume output loudest, speaker at 3
	reset_values: assert property (@(posedge clk)
		!rst_n |=> readdata == 8'h00 && !irq_5 && !irq_7 && !irq_10 &&
		{vol_master_l, vol_master_r, vol_cd_l, vol_cd_r, vol_line_l, vol_line_r} ==
		{6{vol_level_t'(5'd31)}} && vol_spk == 2'd3)
	else begin
		$error("outputs not at their reset values");
		fails = fails + 1;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// held low for 10 rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== rtl/sound_card.sv ====
`timescale 1ns/100ps

module sound_card #(
	parameter int TICK_HZ  = 1000000,
	parameter int RESET_US = 3
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cs,
	input  logic [3:0]  address,
	input  logic        read,
	input  logic        write,
	input  logic [7:0]  writedata,
	output logic [7:0]  readdata,
	input  logic [27:0] clock_rate,
	input  logic [15:0] fm_sample_l,
	input  logic [15:0] fm_sample_r,
	output logic        irq_5,
	output logic        irq_7,
	output logic        irq_10,
	output logic [15:0] sample_l,
	output logic [15:0] sample_r,
	output logic [4:0]  vol_master_l,
	output logic [4:0]  vol_master_r,
	output logic [4:0]  vol_cd_l,
	output logic [4:0]  vol_cd_r,
	output logic [4:0]  vol_line_l,
	output logic [4:0]  vol_line_r,
	output logic [1:0]  vol_spk
);

	import sound_pkg::*;
	import audio_pkg::*;

	logic       sb_read;
	logic       tick;
	logic [7:0] dsp_rdata;
	logic [7:0] mix_rdata;
	logic       dsp_irq;
	logic [2:0] irq_sel;
	sample_t    dac_sample;
	vol_level_t vol_voice_l, vol_voice_r;
	vol_level_t vol_synth_l, vol_synth_r;
	stereo_t    dsp_st, fm_st, mix_st;

	io_bus_if bus ();

	assign sb_read   = read & cs;
	assign bus.rd    = sb_read;
	assign bus.wr    = write & cs;
	assign bus.addr  = address;
	assign bus.wdata = writedata;

	// sampled on the read pulse, held until the next one
	always_ff @(posedge clk) begin
		if (!rst_n)
			readdata <= 8'h00;
		else if (sb_read)
			readdata <= (address == PORT_MIX_INDEX || address == PORT_MIX_DATA) ?
			            mix_rdata : dsp_rdata;
	end

	tick_gen #(.TICK_HZ(TICK_HZ)) tick_gen0 (
		.clk(clk), .rst_n(rst_n), .clock_rate(clock_rate), .tick(tick)
	);

	sound_dsp #(.RESET_US(RESET_US)) sound_dsp0 (
		.clk(clk), .rst_n(rst_n), .tick(tick), .bus(bus),
		.rdata(dsp_rdata), .irq(dsp_irq), .dac_sample(dac_sample)
	);

	sound_mixer_regs sound_mixer_regs0 (
		.clk(clk), .rst_n(rst_n), .bus(bus), .irq_pending(dsp_irq),
		.rdata(mix_rdata), .irq_sel(irq_sel),
		.vol_master_l(vol_master_l), .vol_master_r(vol_master_r),
		.vol_voice_l(vol_voice_l), .vol_voice_r(vol_voice_r),
		.vol_synth_l(vol_synth_l), .vol_synth_r(vol_synth_r),
		.vol_cd_l(vol_cd_l), .vol_cd_r(vol_cd_r),
		.vol_line_l(vol_line_l), .vol_line_r(vol_line_r),
		.vol_spk(vol_spk)
	);

	assign irq_5  = dsp_irq & irq_sel[0];
	assign irq_7  = dsp_irq & irq_sel[1];
	assign irq_10 = dsp_irq & irq_sel[2];

	assign dsp_st = '{left: dac_sample, right: dac_sample}; // mono DAC on both sides
	assign fm_st  = '{left: fm_sample_l, right: fm_sample_r};

	sample_mixer sample_mixer0 (
		.clk(clk), .dsp(dsp_st), .fm(fm_st),
		.atten_dsp_l(atten_t'(4'd15 - vol_voice_l[4:1])),
		.atten_dsp_r(atten_t'(4'd15 - vol_voice_r[4:1])),
		.atten_fm_l(atten_t'(4'd15 - vol_synth_l[4:1])),
		.atten_fm_r(atten_t'(4'd15 - vol_synth_r[4:1])),
		.mix(mix_st)
	);

	assign sample_l = mix_st.left;
	assign sample_r = mix_st.right;

endmodule

// ==== rtl/sample_mixer.sv ====
`timescale 1ns/100ps

module sample_mixer (
	input  logic               clk,
	input  audio_pkg::stereo_t dsp,
	input  audio_pkg::stereo_t fm,
	input  audio_pkg::atten_t  atten_dsp_l,
	input  audio_pkg::atten_t  atten_dsp_r,
	input  audio_pkg::atten_t  atten_fm_l,
	input  audio_pkg::atten_t  atten_fm_r,
	output audio_pkg::stereo_t mix
);

	import audio_pkg::*;

	sample_t dsp_l;
	sample_t dsp_r;
	sample_t fm_l;
	sample_t fm_r;

	// halves keep the sum inside 16 bits
	function automatic sample_t half_sum(input sample_t a, input sample_t b);
		return (a >>> 1) + (b >>> 1);
	endfunction

	// stage 1, volume as a shift
	always_ff @(posedge clk) begin
		dsp_l <= dsp.left >>> atten_dsp_l;
		dsp_r <= dsp.right >>> atten_dsp_r;
		fm_l  <= fm.left >>> atten_fm_l;
		fm_r  <= fm.right >>> atten_fm_r;
	end

	// stage 2
	always_ff @(posedge clk) begin
		mix.left  <= half_sum(dsp_l, fm_l);
		mix.right <= half_sum(dsp_r, fm_r);
	end

endmodule

// ==== rtl/sound_mixer_regs.sv ====
`timescale 1ns/100ps

module sound_mixer_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	io_bus_if.dev                 bus,
	input  logic                  irq_pending,
	output logic [7:0]            rdata,
	output logic [2:0]            irq_sel, // one-hot {10, 7, 5}
	output sound_pkg::vol_level_t vol_master_l,
	output sound_pkg::vol_level_t vol_master_r,
	output sound_pkg::vol_level_t vol_voice_l,
	output sound_pkg::vol_level_t vol_voice_r,
	output sound_pkg::vol_level_t vol_synth_l,
	output sound_pkg::vol_level_t vol_synth_r,
	output sound_pkg::vol_level_t vol_cd_l,
	output sound_pkg::vol_level_t vol_cd_r,
	output sound_pkg::vol_level_t vol_line_l,
	output sound_pkg::vol_level_t vol_line_r,
	output logic [1:0]            vol_spk
);

	import sound_pkg::*;

	logic [7:0] index;
	logic       sbpro;
	logic       stereo_en;
	logic       data_wr;
	logic       mix_reset;
	vol_byte_u  wbyte;
	logic [7:0] vol_mask;
	logic [7:0] mix_val;

	assign wbyte     = bus.wdata;
	assign data_wr   = bus.wr && bus.addr == PORT_MIX_DATA;
	assign mix_reset = data_wr && index == MIX_RESET;
	assign vol_mask  = sbpro ? 8'hEE : 8'hFF;

	always_ff @(posedge clk) begin
		if (!rst_n)
			index <= 8'h00;
		else if (bus.wr && bus.addr == PORT_MIX_INDEX)
			index <= bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sbpro   <= 1'b0;
			irq_sel <= 3'b001;
		end else if (data_wr && index == MIX_IRQ_SEL) begin
			if (bus.wdata == 8'hAD)
				sbpro <= 1'b1;
			else if (bus.wdata == 8'hAE)
				sbpro <= 1'b0;
			else begin
				case (bus.wdata[3:2])
					2'b10:   irq_sel <= 3'b100;
					2'b01:   irq_sel <= 3'b010;
					default: irq_sel <= 3'b001;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || mix_reset) begin
			{vol_master_l, vol_master_r} <= 10'h3FF;
			{vol_voice_l, vol_voice_r}   <= 10'h3FF;
			{vol_synth_l, vol_synth_r}   <= 10'h3FF;
			{vol_cd_l, vol_cd_r}         <= 10'h3FF;
			{vol_line_l, vol_line_r}     <= 10'h3FF;
			vol_spk                      <= 2'd3;
			stereo_en                    <= 1'b0;
		end else if (data_wr) begin
			// stereo pairs, nibble coded
			case (index)
				MIX_STEREO: stereo_en <= bus.wdata[1] & sbpro;
				MIX_VOICE: begin
					vol_voice_l <= pro_level(wbyte.pro.left);
					vol_voice_r <= pro_level(wbyte.pro.right);
				end
				MIX_MASTER: begin
					vol_master_l <= pro_level(wbyte.pro.left);
					vol_master_r <= pro_level(wbyte.pro.right);
				end
				MIX_SYNTH: begin
					vol_synth_l <= pro_level(wbyte.pro.left);
					vol_synth_r <= pro_level(wbyte.pro.right);
				end
				MIX_CD: begin
					vol_cd_l <= pro_level(wbyte.pro.left);
					vol_cd_r <= pro_level(wbyte.pro.right);
				end
				MIX_LINE: begin
					vol_line_l <= pro_level(wbyte.pro.left);
					vol_line_r <= pro_level(wbyte.pro.right);
				end
				default: ;
			endcase
			if (!sbpro) begin // per-channel registers exist on SB16 only
				case (index)
					MIX_MASTER_L: vol_master_l <= wbyte.sb16.level;
					MIX_MASTER_R: vol_master_r <= wbyte.sb16.level;
					MIX_VOICE_L:  vol_voice_l  <= wbyte.sb16.level;
					MIX_VOICE_R:  vol_voice_r  <= wbyte.sb16.level;
					MIX_SYNTH_L:  vol_synth_l  <= wbyte.sb16.level;
					MIX_SYNTH_R:  vol_synth_r  <= wbyte.sb16.level;
					MIX_CD_L:     vol_cd_l     <= wbyte.sb16.level;
					MIX_CD_R:     vol_cd_r     <= wbyte.sb16.level;
					MIX_LINE_L:   vol_line_l   <= wbyte.sb16.level;
					MIX_LINE_R:   vol_line_r   <= wbyte.sb16.level;
					MIX_SPK:      vol_spk      <= wbyte.sb16.level[4:3];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		mix_val = 8'h00;
		case (index)
			MIX_VOICE:    mix_val = {vol_voice_l[4:1], vol_voice_r[4:1]} & vol_mask;
			MIX_STEREO:   mix_val = {6'd0, stereo_en, 1'b0};
			MIX_MASTER:   mix_val = {vol_master_l[4:1], vol_master_r[4:1]} & vol_mask;
			MIX_SYNTH:    mix_val = {vol_synth_l[4:1], vol_synth_r[4:1]} & vol_mask;
			MIX_CD:       mix_val = {vol_cd_l[4:1], vol_cd_r[4:1]} & vol_mask;
			MIX_LINE:     mix_val = {vol_line_l[4:1], vol_line_r[4:1]} & vol_mask;
			MIX_IRQ_SEL:  mix_val = {4'h0, irq_sel, 1'b0};
			MIX_IRQ_STAT: mix_val = {7'd0, irq_pending};
			default: ;
		endcase
		if (!sbpro) begin
			case (index)
				MIX_MASTER_L: mix_val = {vol_master_l, 3'd0};
				MIX_MASTER_R: mix_val = {vol_master_r, 3'd0};
				MIX_VOICE_L:  mix_val = {vol_voice_l, 3'd0};
				MIX_VOICE_R:  mix_val = {vol_voice_r, 3'd0};
				MIX_SYNTH_L:  mix_val = {vol_synth_l, 3'd0};
				MIX_SYNTH_R:  mix_val = {vol_synth_r, 3'd0};
				MIX_CD_L:     mix_val = {vol_cd_l, 3'd0};
				MIX_CD_R:     mix_val = {vol_cd_r, 3'd0};
				MIX_LINE_L:   mix_val = {vol_line_l, 3'd0};
				MIX_LINE_R:   mix_val = {vol_line_r, 3'd0};
				MIX_SPK:      mix_val = {vol_spk, 6'd0};
				default: ;
			endcase
		end
	end

	assign rdata = (bus.addr == PORT_MIX_INDEX) ? index :
	               (bus.addr == PORT_MIX_DATA)  ? mix_val : 8'h00;

endmodule

// ==== rtl/sound_dsp.sv ====
`timescale 1ns/100ps

module sound_dsp #(
	parameter int RESET_US = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              tick,
	io_bus_if.dev             bus,
	output logic [7:0]        rdata,
	output logic              irq,
	output audio_pkg::sample_t dac_sample
);

	import sound_pkg::*;
	import audio_pkg::*;

	localparam int CNT_W = $clog2(RESET_US + 1);

	logic             reset_arm;
	logic             waiting;
	logic [CNT_W-1:0] wait_cnt;
	logic             expect_dac;
	logic             spk_on;
	sample_t          dac_value;

	logic [7:0]       q_data [2];
	logic [1:0]       q_cnt;

	logic             reset_wr;
	logic             dsp_clear;
	logic             cmd_wr;
	logic             ver_cmd;
	logic             push;
	logic             pop;
	logic             stat_rd;

	assign reset_wr  = bus.wr && bus.addr == PORT_DSP_RESET;
	assign dsp_clear = reset_wr && bus.wdata[0];
	assign cmd_wr    = bus.wr && bus.addr == PORT_DSP_WRITE;
	assign ver_cmd   = cmd_wr && !expect_dac && bus.wdata == DSP_CMD_VERSION;
	assign push      = waiting && tick && wait_cnt == CNT_W'(1);
	assign pop       = bus.rd && bus.addr == PORT_DSP_READ && q_cnt != 2'd0;
	assign stat_rd   = bus.rd && bus.addr == PORT_DSP_STATUS;

	// 1 then 0 on the reset port
	always_ff @(posedge clk) begin
		if (!rst_n)
			reset_arm <= 1'b0;
		else if (reset_wr)
			reset_arm <= bus.wdata[0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n || dsp_clear) begin
			waiting    <= 1'b0;
			wait_cnt   <= '0;
			expect_dac <= 1'b0;
			spk_on     <= 1'b0;
			irq        <= 1'b0;
			dac_value  <= '0;
		end else begin
			if (reset_wr && reset_arm) begin // falling edge of the reset bit
				waiting  <= 1'b1;
				wait_cnt <= CNT_W'(RESET_US);
			end else if (waiting && tick) begin
				if (wait_cnt == CNT_W'(1))
					waiting <= 1'b0;
				wait_cnt <= wait_cnt - CNT_W'(1);
			end

			if (cmd_wr) begin
				if (expect_dac) begin
					dac_value  <= {~bus.wdata[7], bus.wdata[6:0], 8'h00}; // unsigned byte to signed
					expect_dac <= 1'b0;
				end else begin
					case (bus.wdata)
						DSP_CMD_DAC:     expect_dac <= 1'b1;
						DSP_CMD_SPK_ON:  spk_on <= 1'b1;
						DSP_CMD_SPK_OFF: spk_on <= 1'b0;
						DSP_CMD_IRQ:     irq <= 1'b1;
						default: ;
					endcase
				end
			end

			if (stat_rd)
				irq <= 1'b0; // status read acknowledges
		end
	end

	// two-entry reply queue, head at index 0
	always_ff @(posedge clk) begin
		if (!rst_n || dsp_clear) begin
			q_cnt <= 2'd0;
		end else if (ver_cmd) begin
			q_data[0] <= DSP_VERSION_MAJOR;
			q_data[1] <= DSP_VERSION_MINOR;
			q_cnt     <= 2'd2;
		end else begin
			case ({push, pop})
				2'b10: begin
					if (q_cnt != 2'd2) begin
						q_data[q_cnt[0]] <= DSP_RESET_REPLY;
						q_cnt            <= q_cnt + 2'd1;
					end
				end
				2'b01: begin
					q_data[0] <= q_data[1];
					q_cnt     <= q_cnt - 2'd1;
				end
				2'b11: begin // count unchanged
					q_data[0] <= (q_cnt == 2'd2) ? q_data[1] : DSP_RESET_REPLY;
					q_data[1] <= DSP_RESET_REPLY;
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (bus.addr)
			PORT_DSP_READ:   rdata = (q_cnt != 2'd0) ? q_data[0] : 8'h00;
			PORT_DSP_STATUS: rdata = {q_cnt != 2'd0, 7'd0};
			PORT_DSP_WRITE:  rdata = 8'h00; // never busy
			default:         rdata = 8'h00;
		endcase
	end

	assign dac_sample = spk_on ? dac_value : '0;

endmodule

// ==== rtl/tick_gen.sv ====
`timescale 1ns/100ps

module tick_gen #(
	parameter int TICK_HZ = 1000000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [27:0] clock_rate,
	output logic        tick
);

	logic [27:0] clk_rate;
	logic [27:0] acc;
	logic [27:0] sum;

	always_ff @(posedge clk) clk_rate <= clock_rate; // one register stage on entry

	assign sum = acc + 28'(TICK_HZ);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc  <= '0;
			tick <= 1'b0;
		end else if (sum >= clk_rate) begin
			acc  <= sum - clk_rate; // keep the remainder
			tick <= 1'b1;
		end else begin
			acc  <= sum;
			tick <= 1'b0;
		end
	end

endmodule

// ==== rtl/io_bus_if.sv ====
`timescale 1ns/100ps

// decoded host strobes, already qualified by cs
interface io_bus_if;

	logic       rd;
	logic       wr;
	logic [3:0] addr;
	logic [7:0] wdata;

	modport host (
		output rd,
		output wr,
		output addr,
		output wdata
	);

	modport dev (
		input rd,
		input wr,
		input addr,
		input wdata
	);

endinterface

// ==== rtl/audio_pkg.sv ====
package audio_pkg;

	typedef logic signed [15:0] sample_t;

	// arithmetic right shift applied to a sample
	typedef logic [3:0] atten_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

endpackage

// ==== rtl/sound_pkg.sv ====
package sound_pkg;

	// offsets inside the 16-byte window
	localparam logic [3:0] PORT_MIX_INDEX  = 4'h4;
	localparam logic [3:0] PORT_MIX_DATA   = 4'h5;
	localparam logic [3:0] PORT_DSP_RESET  = 4'h6;
	localparam logic [3:0] PORT_DSP_READ   = 4'hA;
	localparam logic [3:0] PORT_DSP_WRITE  = 4'hC;
	localparam logic [3:0] PORT_DSP_STATUS = 4'hE;

	// mixer register indices
	localparam logic [7:0] MIX_RESET    = 8'h00;
	localparam logic [7:0] MIX_VOICE    = 8'h04;
	localparam logic [7:0] MIX_STEREO   = 8'h0E;
	localparam logic [7:0] MIX_MASTER   = 8'h22;
	localparam logic [7:0] MIX_SYNTH    = 8'h26;
	localparam logic [7:0] MIX_CD       = 8'h28;
	localparam logic [7:0] MIX_LINE     = 8'h2E;
	localparam logic [7:0] MIX_MASTER_L = 8'h30;
	localparam logic [7:0] MIX_MASTER_R = 8'h31;
	localparam logic [7:0] MIX_VOICE_L  = 8'h32;
	localparam logic [7:0] MIX_VOICE_R  = 8'h33;
	localparam logic [7:0] MIX_SYNTH_L  = 8'h34;
	localparam logic [7:0] MIX_SYNTH_R  = 8'h35;
	localparam logic [7:0] MIX_CD_L     = 8'h36;
	localparam logic [7:0] MIX_CD_R     = 8'h37;
	localparam logic [7:0] MIX_LINE_L   = 8'h38;
	localparam logic [7:0] MIX_LINE_R   = 8'h39;
	localparam logic [7:0] MIX_SPK      = 8'h3B;
	localparam logic [7:0] MIX_IRQ_SEL  = 8'h80;
	localparam logic [7:0] MIX_IRQ_STAT = 8'h82;

	localparam logic [7:0] DSP_CMD_DAC     = 8'h10;
	localparam logic [7:0] DSP_CMD_SPK_ON  = 8'hD1;
	localparam logic [7:0] DSP_CMD_SPK_OFF = 8'hD3;
	localparam logic [7:0] DSP_CMD_VERSION = 8'hE1;
	localparam logic [7:0] DSP_CMD_IRQ     = 8'hF2;

	localparam logic [7:0] DSP_RESET_REPLY   = 8'hAA;
	localparam logic [7:0] DSP_VERSION_MAJOR = 8'h04;
	localparam logic [7:0] DSP_VERSION_MINOR = 8'h05;

	typedef logic [4:0] vol_level_t; // 31 = loudest

	// one mixer data byte, seen as two nibbles or one 5-bit level
	typedef union packed {
		struct packed {
			logic [3:0] left;
			logic [3:0] right;
		} pro;
		struct packed {
			vol_level_t level;
			logic [2:0] rsvd;
		} sb16;
	} vol_byte_u;

	// nibble to level, top bit repeated into the lsb
	function automatic vol_level_t pro_level(input logic [3:0] nib);
		return {nib, nib[3]};
	endfunction

endpackage
